// ==== src/console_consts.svh ====
`ifndef CONSOLE_CONSTS_SVH
`define CONSOLE_CONSTS_SVH

`define DATA_WIDTH  32
`define MEM_DEPTH   16
`define MEM_AW      4
`define MAX_DIGITS  10
`define SW_WIDTH    16
`define AXI_AW      8            // byte address width of the host port

// scanned keypad codes, {row, col}, one-cold per nibble
`define KEY_ZERO    8'b0111_1101
`define KEY_ONE     8'b1110_1110
`define KEY_TWO     8'b1110_1101
`define KEY_THREE   8'b1110_1011
`define KEY_FOUR    8'b1101_1110
`define KEY_FIVE    8'b1101_1101
`define KEY_SIX     8'b1101_1011
`define KEY_SEVEN   8'b1011_1110
`define KEY_EIGHT   8'b1011_1101
`define KEY_NINE    8'b1011_1011
`define KEY_BACK    8'b0111_1110 // "*"
`define KEY_ENTER   8'b0111_1011 // "#"
`define KEY_PAUSE   8'b1110_0111 // "A"
`define KEY_TOGGLE  8'b1101_0111 // "B"

`define REG_CTRL    8'h00
`define REG_VALUE   8'h04
`define MEM_BASE    8'h40

`endif

// ==== src/console_pkg.sv ====
package console_pkg;

    // states of the entry unit
    typedef enum logic [2:0] {
        BLOCK,
        KEYPAD,
        SWITCH,
        HALT,
        STORE
    } entry_state_t;

    // what a decoded key press asks for
    typedef enum logic [2:0] {
        OP_NONE,
        OP_DIGIT,
        OP_BACK,
        OP_ENTER,
        OP_PAUSE,
        OP_TOGGLE
    } key_op_t;

    // last requester served by the memory arbiter
    typedef enum logic {
        OWN_ENTRY,
        OWN_HOST
    } owner_t;

endpackage

// ==== src/mem_bus_if.sv ====
`include "console_consts.svh"

interface mem_bus_if;
    logic                   req;   // held until gnt
    logic                   we;
    logic [`MEM_AW-1:0]     addr;
    logic [`DATA_WIDTH-1:0] wdata;
    logic [`DATA_WIDTH-1:0] rdata; // valid the cycle after gnt
    logic                   gnt;   // one-cycle grant

    modport requester (
        output req, we, addr, wdata,
        input  gnt, rdata
    );

    modport arbiter (
        input  req, we, addr, wdata,
        output gnt, rdata
    );
endinterface

// ==== src/keypad_decoder.sv ====
`include "console_consts.svh"

module keypad_decoder (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic [7:0]           key_code,  // scanned {row, col}, zero when released
    output logic                 key_valid,
    output console_pkg::key_op_t key_op,
    output logic [3:0]           key_digit
);
    import console_pkg::*;

    logic [7:0] prev_code;
    key_op_t    dec_op;
    logic [3:0] dec_digit;

    always_comb begin
        dec_op    = OP_DIGIT;
        dec_digit = 4'd0;
        case (key_code)
            `KEY_ZERO:   dec_digit = 4'd0;
            `KEY_ONE:    dec_digit = 4'd1;
            `KEY_TWO:    dec_digit = 4'd2;
            `KEY_THREE:  dec_digit = 4'd3;
            `KEY_FOUR:   dec_digit = 4'd4;
            `KEY_FIVE:   dec_digit = 4'd5;
            `KEY_SIX:    dec_digit = 4'd6;
            `KEY_SEVEN:  dec_digit = 4'd7;
            `KEY_EIGHT:  dec_digit = 4'd8;
            `KEY_NINE:   dec_digit = 4'd9;
            `KEY_BACK:   dec_op    = OP_BACK;
            `KEY_ENTER:  dec_op    = OP_ENTER;
            `KEY_PAUSE:  dec_op    = OP_PAUSE;
            `KEY_TOGGLE: dec_op    = OP_TOGGLE;
            default:     dec_op    = OP_NONE;   // released or unmapped key
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            prev_code <= 8'd0;
            key_valid <= 1'b0;
        end else begin
            prev_code <= key_code;
            key_valid <= (prev_code == 8'd0) && (dec_op != OP_NONE); // press edge only
        end
    end

    always_ff @(posedge clk) begin
        key_op    <= dec_op;
        key_digit <= dec_digit;
    end
endmodule

// ==== src/entry_unit.sv ====
`include "console_consts.svh"

module entry_unit (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   key_valid,
    input  console_pkg::key_op_t   key_op,
    input  logic [3:0]             key_digit,
    input  logic                   arm,          // host armed a request
    input  logic [`MEM_AW-1:0]     dest_addr,
    input  logic                   ignore_pause, // resume press is locked out
    input  logic [`SW_WIDTH-1:0]   sw,
    output logic                   input_complete,
    output logic                   switch_enable,
    output logic                   cpu_pause,
    output logic [`DATA_WIDTH-1:0] entry_value,
    output logic                   active,
    output logic                   overflow_9th,
    output logic                   overflow_10th,
    mem_bus_if.requester           mem
);
    import console_pkg::*;

    entry_state_t state, saved_state;
    logic [3:0]   digit_count;
    logic         digit_ok;

    assign overflow_9th  = (digit_count >= 4'(`MAX_DIGITS - 1));
    assign overflow_10th = (digit_count == 4'(`MAX_DIGITS));
    assign active        = (state == KEYPAD) || (state == SWITCH) || (state == HALT);

    // below the limit, and no leading zero
    assign digit_ok = (digit_count < 4'(`MAX_DIGITS)) &&
                      ((key_digit != 4'd0) || (entry_value != '0));

    // the stored word is whatever entry_value holds in STORE
    assign mem.req   = (state == STORE);
    assign mem.we    = 1'b1;
    assign mem.addr  = dest_addr;
    assign mem.wdata = entry_value;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state          <= BLOCK;
            saved_state    <= BLOCK;
            digit_count    <= 4'd0;
            entry_value    <= '0;
            input_complete <= 1'b0;
            switch_enable  <= 1'b0;
            cpu_pause      <= 1'b0;
        end else begin
            case (state)
                BLOCK: begin
                    if (key_valid && key_op == OP_PAUSE) begin
                        saved_state <= state;
                        state       <= HALT;
                        cpu_pause   <= 1'b1;
                    end else if (arm) begin
                        state          <= KEYPAD;
                        entry_value    <= '0;
                        digit_count    <= 4'd0;
                        input_complete <= 1'b0;
                        switch_enable  <= 1'b0;
                    end
                end
                KEYPAD, SWITCH: begin
                    if (key_valid) begin
                        case (key_op)
                            OP_TOGGLE: begin
                                state         <= (state == KEYPAD) ? SWITCH : KEYPAD;
                                switch_enable <= (state == KEYPAD);
                            end
                            OP_PAUSE: begin
                                saved_state <= state;
                                state       <= HALT;
                                cpu_pause   <= 1'b1;
                            end
                            OP_ENTER: begin
                                state       <= STORE;
                                digit_count <= 4'd0;
                                if (state == SWITCH)
                                    entry_value <= `DATA_WIDTH'(sw); // zero-extended
                            end
                            OP_BACK: begin
                                if (state == KEYPAD && digit_count != 4'd0) begin
                                    entry_value <= entry_value / 10;
                                    digit_count <= digit_count - 4'd1;
                                end
                            end
                            OP_DIGIT: begin
                                if (state == KEYPAD && digit_ok) begin
                                    entry_value <= entry_value * 10 + `DATA_WIDTH'(key_digit);
                                    digit_count <= digit_count + 4'd1;
                                end
                            end
                            default: ;
                        endcase
                    end
                end
                HALT: begin
                    if (key_valid && key_op == OP_PAUSE && !ignore_pause) begin
                        state     <= saved_state;
                        cpu_pause <= 1'b0;
                    end
                end
                STORE: begin
                    if (mem.gnt) begin
                        state          <= BLOCK;
                        input_complete <= 1'b1;
                    end
                end
                default: state <= BLOCK;
            endcase
        end
    end
endmodule

// ==== src/axil_host_port.sv ====
`include "console_consts.svh"

module axil_host_port (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic [`AXI_AW-1:0]       awaddr,
    input  logic                     awvalid,
    output logic                     awready,
    input  logic [`DATA_WIDTH-1:0]   wdata,
    input  logic [`DATA_WIDTH/8-1:0] wstrb,
    input  logic                     wvalid,
    output logic                     wready,
    output logic [1:0]               bresp,
    output logic                     bvalid,
    input  logic                     bready,
    input  logic [`AXI_AW-1:0]       araddr,
    input  logic                     arvalid,
    output logic                     arready,
    output logic [`DATA_WIDTH-1:0]   rdata,
    output logic [1:0]               rresp,
    output logic                     rvalid,
    input  logic                     rready,
    input  logic                     input_complete,
    input  logic                     switch_enable,
    input  logic                     cpu_pause,
    input  logic                     active,
    input  logic [`DATA_WIDTH-1:0]   entry_value,
    output logic                     arm,
    output logic [`MEM_AW-1:0]       dest_addr,
    mem_bus_if.requester             mem
);
    typedef enum logic [2:0] {
        H_IDLE,
        H_REG,   // register access, one cycle before the response
        H_MEM,   // waiting for the arbiter
        H_MRD,   // memory read data arrives
        H_RESP
    } host_state_t;

    host_state_t              state;
    logic [`AXI_AW-1:0]       addr_q, new_addr;
    logic [`DATA_WIDTH-1:0]   wdata_q, reg_rdata;
    logic                     is_write, wr_hs, rd_hs, new_is_mem;

    assign awready = (state == H_IDLE) && awvalid && wvalid; // AW and W taken together
    assign wready  = awready;
    assign arready = (state == H_IDLE) && !(awvalid && wvalid); // writes win a tie
    assign wr_hs   = awready;
    assign rd_hs   = arready && arvalid;
    assign bresp   = 2'b00;
    assign rresp   = 2'b00;

    assign new_addr   = wr_hs ? awaddr : araddr;
    assign new_is_mem = (new_addr >= `MEM_BASE) && (new_addr < `MEM_BASE + 4 * `MEM_DEPTH);

    assign mem.req   = (state == H_MEM);
    assign mem.we    = is_write;
    assign mem.addr  = addr_q[`MEM_AW+1:2]; // byte to word address
    assign mem.wdata = wdata_q;

    always_comb begin
        case (addr_q)
            `REG_CTRL:  reg_rdata = `DATA_WIDTH'({active, cpu_pause, switch_enable,
                                                  input_complete});
            `REG_VALUE: reg_rdata = entry_value;
            default:    reg_rdata = '0;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state  <= H_IDLE;
            bvalid <= 1'b0;
            rvalid <= 1'b0;
            arm    <= 1'b0;
        end else begin
            arm <= wr_hs && (awaddr == `REG_CTRL) && wstrb[0] && wdata[0];
            case (state)
                H_IDLE:
                    if (wr_hs || rd_hs)
                        state <= new_is_mem ? H_MEM : H_REG;
                H_REG: begin
                    bvalid <= is_write;
                    rvalid <= !is_write;
                    state  <= H_RESP;
                end
                H_MEM:
                    if (mem.gnt) begin
                        bvalid <= is_write;
                        state  <= is_write ? H_RESP : H_MRD;
                    end
                H_MRD: begin
                    rvalid <= 1'b1;
                    state  <= H_RESP;
                end
                H_RESP:
                    if ((bvalid && bready) || (rvalid && rready)) begin
                        bvalid <= 1'b0;
                        rvalid <= 1'b0;
                        state  <= H_IDLE;
                    end
                default: state <= H_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (wr_hs || rd_hs) begin
            addr_q   <= new_addr;
            is_write <= wr_hs;
            wdata_q  <= wdata;
        end
        if (wr_hs && awaddr == `REG_CTRL && wstrb[0] && wdata[0])
            dest_addr <= wdata[7:4];
        if (state == H_REG)
            rdata <= reg_rdata;
        else if (state == H_MRD)
            rdata <= mem.rdata;
    end
endmodule

// ==== src/mem_arbiter.sv ====
`include "console_consts.svh"

module mem_arbiter (
    input  logic                   clk,
    input  logic                   rst_n,
    mem_bus_if.arbiter             entry,
    mem_bus_if.arbiter             host,
    output logic                   mem_we,
    output logic [`MEM_AW-1:0]     mem_addr,
    output logic [`DATA_WIDTH-1:0] mem_wdata,
    input  logic [`DATA_WIDTH-1:0] mem_rdata
);
    import console_pkg::*;

    owner_t last_owner;  // also marks who gets this cycle's read data
    logic   grant_host, grant_entry;

    // on a tie the host wins only if the entry unit went last
    assign grant_host  = host.req && (!entry.req || last_owner == OWN_ENTRY);
    assign grant_entry = entry.req && !grant_host;

    assign entry.gnt = grant_entry;
    assign host.gnt  = grant_host;

    assign mem_we    = grant_host ? host.we    : (grant_entry && entry.we);
    assign mem_addr  = grant_host ? host.addr  : entry.addr;
    assign mem_wdata = grant_host ? host.wdata : entry.wdata;

    assign entry.rdata = (last_owner == OWN_ENTRY) ? mem_rdata : '0;
    assign host.rdata  = (last_owner == OWN_HOST)  ? mem_rdata : '0;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            last_owner <= OWN_ENTRY;
        else if (grant_host)
            last_owner <= OWN_HOST;
        else if (grant_entry)
            last_owner <= OWN_ENTRY;
    end
endmodule

// ==== src/data_mem.sv ====
`include "console_consts.svh"

module data_mem (
    input  logic                   clk,
    input  logic                   we,
    input  logic [`MEM_AW-1:0]     addr,
    input  logic [`DATA_WIDTH-1:0] wdata,
    output logic [`DATA_WIDTH-1:0] rdata
);
    logic [`DATA_WIDTH-1:0] words [`MEM_DEPTH];

    always_ff @(posedge clk) begin
        if (we)
            words[addr] <= wdata;
        rdata <= words[addr];  // read-before-write on the same word
    end
endmodule

// ==== src/console_top.sv ====
`include "console_consts.svh"

module console_top (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic [7:0]               key_code,
    input  logic                     ignore_pause,
    input  logic [`SW_WIDTH-1:0]     sw,
    input  logic [`AXI_AW-1:0]       awaddr,
    input  logic                     awvalid,
    output logic                     awready,
    input  logic [`DATA_WIDTH-1:0]   wdata,
    input  logic [`DATA_WIDTH/8-1:0] wstrb,
    input  logic                     wvalid,
    output logic                     wready,
    output logic [1:0]               bresp,
    output logic                     bvalid,
    input  logic                     bready,
    input  logic [`AXI_AW-1:0]       araddr,
    input  logic                     arvalid,
    output logic                     arready,
    output logic [`DATA_WIDTH-1:0]   rdata,
    output logic [1:0]               rresp,
    output logic                     rvalid,
    input  logic                     rready,
    output logic                     switch_enable,
    output logic                     cpu_pause,
    output logic                     overflow_9th,
    output logic                     overflow_10th
);
    import console_pkg::*;

    key_op_t                key_op;
    logic                   key_valid, arm, input_complete, active, mem_we;
    logic [3:0]             key_digit;
    logic [`MEM_AW-1:0]     dest_addr, mem_addr;
    logic [`DATA_WIDTH-1:0] entry_value, mem_wdata, mem_rdata;

    mem_bus_if entry_bus ();
    mem_bus_if host_bus ();

    keypad_decoder u_keypad (
        .clk, .rst_n, .key_code, .key_valid, .key_op, .key_digit
    );

    entry_unit u_entry (
        .clk, .rst_n, .key_valid, .key_op, .key_digit, .arm, .dest_addr,
        .ignore_pause, .sw, .input_complete, .switch_enable, .cpu_pause,
        .entry_value, .active, .overflow_9th, .overflow_10th, .mem(entry_bus)
    );

    axil_host_port u_host (
        .clk, .rst_n, .awaddr, .awvalid, .awready, .wdata, .wstrb, .wvalid,
        .wready, .bresp, .bvalid, .bready, .araddr, .arvalid, .arready, .rdata,
        .rresp, .rvalid, .rready, .input_complete, .switch_enable, .cpu_pause,
        .active, .entry_value, .arm, .dest_addr, .mem(host_bus)
    );

    mem_arbiter u_arb (
        .clk, .rst_n, .entry(entry_bus), .host(host_bus),
        .mem_we, .mem_addr, .mem_wdata, .mem_rdata
    );

    data_mem u_mem (
        .clk, .we(mem_we), .addr(mem_addr), .wdata(mem_wdata), .rdata(mem_rdata)
    );
endmodule

// ==== verification/console_tb.sv ====
`include "console_consts.svh"

module console_tb;
    localparam int NUM_ROWS   = 7;
    localparam int WAIT_LIMIT = 50;  // cycles per handshake
    localparam int POLL_LIMIT = 40;  // status reads while waiting for a store
    localparam int RACE_WORD  = 9;   // host word written alongside an entry store
    localparam int S_BLOCK    = 0;
    localparam int S_KEYPAD   = 1;
    localparam int S_SWITCH   = 2;
    localparam int S_HALT     = 3;

    logic                     clk = 1'b0;
    logic                     rst_n, ignore_pause;
    logic [7:0]               key_code;
    logic [`SW_WIDTH-1:0]     sw;
    logic [`AXI_AW-1:0]       awaddr, araddr;
    logic                     awvalid, wvalid, bready, arvalid, rready;
    logic [`DATA_WIDTH-1:0]   wdata, rdata;
    logic [`DATA_WIDTH/8-1:0] wstrb;
    logic                     awready, wready, bvalid, arready, rvalid;
    logic [1:0]               bresp, rresp;
    logic                     switch_enable, cpu_pause, overflow_9th, overflow_10th;

    // stimulus table: keys are 0-9, b back, e enter, p pause, t toggle,
    // P is a pause pressed while ignore_pause is high
    int    row_dest [NUM_ROWS] = '{1, 2, 3, 4, 5, 6, 7};
    bit    row_race [NUM_ROWS] = '{0, 0, 0, 0, 0, 0, 1};
    string row_keys [NUM_ROWS] = '{"00407e", "b98b5e", "98765432105e", "12t3e",
                                   "7tt1e", "42p7P8p3e", "555e"};
    string row_name [NUM_ROWS] = '{"leading zeros", "backspace", "digit limit",
                                   "switch mode", "double toggle", "pause",
                                   "store under contention"};
    logic [`SW_WIDTH-1:0]   row_sw     [NUM_ROWS];
    logic [`DATA_WIDTH-1:0] row_expect [NUM_ROWS];

    logic [`DATA_WIDTH-1:0] exp_mem   [`MEM_DEPTH];
    bit                     exp_valid [`MEM_DEPTH];
    int                     errors, tests_run, tests_failed;

    // reference model of the entry rules
    int                     m_state, m_saved, m_count;
    logic [`DATA_WIDTH-1:0] m_value;
    logic [`SW_WIDTH-1:0]   m_sw;
    logic                   m_sw_en, m_pause;

    console_top dut0 (
        .clk, .rst_n, .key_code, .ignore_pause, .sw, .awaddr, .awvalid, .awready,
        .wdata, .wstrb, .wvalid, .wready, .bresp, .bvalid, .bready, .araddr,
        .arvalid, .arready, .rdata, .rresp, .rvalid, .rready, .switch_enable,
        .cpu_pause, .overflow_9th, .overflow_10th
    );

    always #2 clk = ~clk;

    function automatic logic [7:0] key_of(input byte c);
        case (c)
            "0":      key_of = `KEY_ZERO;
            "1":      key_of = `KEY_ONE;
            "2":      key_of = `KEY_TWO;
            "3":      key_of = `KEY_THREE;
            "4":      key_of = `KEY_FOUR;
            "5":      key_of = `KEY_FIVE;
            "6":      key_of = `KEY_SIX;
            "7":      key_of = `KEY_SEVEN;
            "8":      key_of = `KEY_EIGHT;
            "9":      key_of = `KEY_NINE;
            "b":      key_of = `KEY_BACK;
            "e":      key_of = `KEY_ENTER;
            "p", "P": key_of = `KEY_PAUSE;
            "t":      key_of = `KEY_TOGGLE;
            default:  key_of = 8'h00;
        endcase
    endfunction

    task automatic model_arm();
        m_state = S_KEYPAD;
        m_value = '0;
        m_count = 0;
        m_sw_en = 1'b0;
    endtask

    task automatic model_key(input byte c);
        logic                   is_digit;
        logic [`DATA_WIDTH-1:0] d;
        is_digit = (c >= "0") && (c <= "9");
        d = 32'(int'(c) - 48);
        if (m_state == S_HALT) begin
            if (c == "p") begin  // resume only when not locked out
                m_state = m_saved;
                m_pause = 1'b0;
            end
        end else if (m_state == S_KEYPAD || m_state == S_SWITCH) begin
            if (c == "t") begin
                m_state = (m_state == S_KEYPAD) ? S_SWITCH : S_KEYPAD;
                m_sw_en = (m_state == S_SWITCH);
            end else if (c == "p" || c == "P") begin
                m_saved = m_state;
                m_state = S_HALT;
                m_pause = 1'b1;
            end else if (c == "e") begin
                if (m_state == S_SWITCH)
                    m_value = {16'h0, m_sw};
                m_count = 0;
                m_state = S_BLOCK;
            end else if (c == "b") begin
                if (m_state == S_KEYPAD && m_count > 0) begin
                    m_value = m_value / 10;
                    m_count = m_count - 1;
                end
            end else if (is_digit && m_state == S_KEYPAD) begin
                if (m_count < `MAX_DIGITS && !(d == 0 && m_value == 0)) begin
                    m_value = m_value * 10 + d;  // wraps modulo 2^32
                    m_count = m_count + 1;
                end
            end
        end
    endtask

    task automatic abort_run(input string why);
        $display("%s timed out at time %0t", why, $time);
        $display("*** TEST FAILED ***");
        $finish;
    endtask

    // all bus tasks start and end just after a falling edge
    task automatic axi_write(input logic [7:0] addr, input logic [31:0] data);
        int n;
        awaddr  = addr;
        wdata   = data;
        wstrb   = 4'hf;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        n = 0;
        #1;
        while (!(awready && wready) && n < WAIT_LIMIT) begin
            @(negedge clk);
            #1;
            n++;
        end
        if (!(awready && wready))
            abort_run("write address and data handshake");
        @(negedge clk);
        awvalid = 1'b0;
        wvalid  = 1'b0;
        bready  = 1'b1;
        n = 0;
        #1;
        while (!bvalid && n < WAIT_LIMIT) begin
            @(negedge clk);
            #1;
            n++;
        end
        if (!bvalid)
            abort_run("write response");
        if (bresp != 2'b00) begin
            $display("Fail at %0t: bresp %b on write to 0x%h", $time, bresp, addr);
            errors++;
        end
        @(negedge clk);
        bready = 1'b0;
    endtask

    task automatic axi_read(input logic [7:0] addr, output logic [31:0] data);
        int n;
        araddr  = addr;
        arvalid = 1'b1;
        n = 0;
        #1;
        while (!arready && n < WAIT_LIMIT) begin
            @(negedge clk);
            #1;
            n++;
        end
        if (!arready)
            abort_run("read address handshake");
        @(negedge clk);
        arvalid = 1'b0;
        rready  = 1'b1;
        n = 0;
        #1;
        while (!rvalid && n < WAIT_LIMIT) begin
            @(negedge clk);
            #1;
            n++;
        end
        if (!rvalid)
            abort_run("read data");
        data = rdata;
        if (rresp != 2'b00) begin
            $display("Fail at %0t: rresp %b on read of 0x%h", $time, rresp, addr);
            errors++;
        end
        @(negedge clk);
        rready = 1'b0;
    endtask

    task automatic check_word(input int w, input logic [31:0] want);
        logic [31:0] got;
        axi_read(8'(`MEM_BASE + 4 * w), got);
        if (got !== want) begin
            $display("Fail at %0t: word %0d holds %0d, expected %0d", $time, w, got, want);
            errors++;
        end
    endtask

    task automatic press_key(input byte c);
        logic [3:0] want;
        int         n;
        ignore_pause = (c == "P");
        key_code     = key_of(c);
        repeat (2) @(negedge clk);
        key_code     = 8'h00;
        ignore_pause = 1'b0;
        @(negedge clk);
        model_key(c);
        want = {m_sw_en, m_pause, m_count >= 9, m_count == 10};
        n = 0;
        while ({switch_enable, cpu_pause, overflow_9th, overflow_10th} != want &&
               n < 8) begin
            @(negedge clk);
            n++;
        end
        if ({switch_enable, cpu_pause, overflow_9th, overflow_10th} != want) begin
            $display("Fail at %0t: after key %c leds %b, expected %b", $time, c,
                     {switch_enable, cpu_pause, overflow_9th, overflow_10th}, want);
            errors++;
        end
    endtask

    task automatic wait_complete();
        logic [31:0] st;
        int          n;
        n = 0;
        axi_read(`REG_CTRL, st);
        while (!st[0] && n < POLL_LIMIT) begin
            axi_read(`REG_CTRL, st);
            n++;
        end
        if (!st[0])
            abort_run("wait for input_complete");
    endtask

    task automatic report_test(input string name, input int errs_before);
        tests_run++;
        if (errors == errs_before) begin
            $display("test %0d %s: ok", tests_run, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: %0d mismatches", tests_run, name, errors - errs_before);
        end
    endtask

    task automatic run_row(input int r);
        int          errs_before, len, i;
        logic [31:0] got, race_data;
        errs_before = errors;
        sw   = row_sw[r];
        m_sw = row_sw[r];
        len  = row_keys[r].len();
        axi_write(`REG_CTRL, {24'h0, 4'(row_dest[r]), 4'b0001});
        model_arm();
        axi_read(`REG_CTRL, got);
        if (got[3:0] != 4'b1000) begin
            $display("Fail at %0t: status %b after arm, expected 1000", $time, got[3:0]);
            errors++;
        end
        for (i = 0; i < len - 1; i++)
            press_key(row_keys[r][i]);
        if (row_race[r]) begin
            race_data = $urandom;
            fork
                press_key(row_keys[r][len-1]);
                begin
                    @(negedge clk);  // host request lands in the store cycle
                    axi_write(8'(`MEM_BASE + 4 * RACE_WORD), race_data);
                end
            join
            exp_mem[RACE_WORD]   = race_data;
            exp_valid[RACE_WORD] = 1'b1;
        end else begin
            press_key(row_keys[r][len-1]);
        end
        wait_complete();
        axi_read(`REG_VALUE, got);
        if (got !== row_expect[r]) begin
            $display("Fail at %0t: entry value %0d, expected %0d", $time, got, row_expect[r]);
            errors++;
        end
        check_word(row_dest[r], row_expect[r]);
        if (row_race[r])
            check_word(RACE_WORD, exp_mem[RACE_WORD]);
        exp_mem[row_dest[r]]   = row_expect[r];
        exp_valid[row_dest[r]] = 1'b1;
        report_test(row_name[r], errs_before);
    endtask

    initial begin
        int          r, i, errs_before;
        logic [31:0] data;
        rst_n        = 1'b0;
        key_code     = 8'h00;
        ignore_pause = 1'b0;
        sw           = '0;
        awaddr       = '0;
        awvalid      = 1'b0;
        wdata        = '0;
        wstrb        = '0;
        wvalid       = 1'b0;
        bready       = 1'b0;
        araddr       = '0;
        arvalid      = 1'b0;
        rready       = 1'b0;
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        m_pause      = 1'b0;
        void'($urandom(32'h57477c30));

        // expected stored words from the reference model
        for (r = 0; r < NUM_ROWS; r++) begin
            row_sw[r] = 16'($urandom);
            m_sw = row_sw[r];
            model_arm();
            for (i = 0; i < row_keys[r].len(); i++)
                model_key(row_keys[r][i]);
            row_expect[r] = m_value;
        end
        for (i = 0; i < `MEM_DEPTH; i++)
            exp_valid[i] = 1'b0;
        m_pause = 1'b0;  // the DUT comes out of reset unpaused

        repeat (5) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);

        errs_before = errors;
        if (switch_enable || cpu_pause || overflow_9th || overflow_10th || bvalid ||
            rvalid) begin
            $display("Fail at %0t: outputs not idle after reset", $time);
            errors++;
        end
        report_test("reset state", errs_before);

        errs_before = errors;
        for (i = 10; i < 14; i++) begin
            data = $urandom;
            axi_write(8'(`MEM_BASE + 4 * i), data);
            exp_mem[i]   = data;
            exp_valid[i] = 1'b1;
        end
        for (i = 10; i < 14; i++)
            check_word(i, exp_mem[i]);
        report_test("host memory round trip", errs_before);

        for (r = 0; r < NUM_ROWS; r++)
            run_row(r);

        errs_before = errors;
        for (i = 0; i < `MEM_DEPTH; i++)
            if (exp_valid[i])
                check_word(i, exp_mem[i]);
        report_test("memory sweep", errs_before);

        $display("summary: %0d tests, %0d ok, %0d failed, %0d failed checks",
                 tests_run, tests_run - tests_failed, tests_failed, errors);
        if (errors == 0)
            $display("*** TEST PASSED ***");
        else
            $display("*** TEST FAILED ***");
        $finish;
    end
endmodule

// ==== sim.f ====
+incdir+src
src/console_pkg.sv
src/mem_bus_if.sv
src/keypad_decoder.sv
src/entry_unit.sv
src/axil_host_port.sv
src/mem_arbiter.sv
src/data_mem.sv
src/console_top.sv
verification/console_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= console_tb
OBJ_DIR   ?= obj_dir
FILELIST  ?= sim.f
VFLAGS    ?= --binary -j 0 -Wno-fatal

SOURCES := $(wildcard src/*.sv src/*.svh verification/*.sv)
BIN     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; \
	echo "$$out" | grep -qF '*** TEST PASSED ***'

clean:
	rm -rf $(OBJ_DIR)
